// ==== list.f ====
+incdir+testbench
rtl/tpuPkg.sv
rtl/ringBufferControl.sv
rtl/loadStoreTokenQueue.sv
rtl/strideAddressGenerator.sv
rtl/dataMemory.sv
rtl/loadStoreUnit.sv
testbench/loadStoreUnitTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the load/store unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f list.f --top-module loadStoreUnitTb -o simLoadStoreUnit

# The log decides the outcome
./obj_dir/simLoadStoreUnit > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TESTS PASSED" sim.log; then
	exit 1
fi
exit 0

// ==== testbench/ldstModel.svh ====
////////////////////
// Reference model for the load/store unit testbench
// Commands are applied in acceptance order, which is also execution order
////////////////////
`ifndef LDST_MODEL_SVH
`define LDST_MODEL_SVH

data_t modelMemory [256];							// Image of the data memory
ldstResult_t expectedResults [$];
logic [TAG_WIDTH-1:0] expectedDones [$];

// Zero image, nothing outstanding
task automatic modelReset();
	for (int i = 0; i < 256; i++) begin
		modelMemory[i] = '0;
	end
	expectedResults.delete();
	expectedDones.delete();
endtask

// Element i sits at base + i * stride modulo 256
function automatic void modelCommand(input accessDesc_t desc, input ldstToken_t token);
	address_t addr;
	ldstResult_t item;
	for (int i = 0; i < int'(desc.length); i++) begin
		addr = address_t'(int'(desc.base) + i * int'(desc.stride));
		if (token.op == OP_STORE) begin
			modelMemory[addr] = token.storeValue;
		end else begin
			item.tag = token.tag;
			item.index = address_t'(i);
			item.data = modelMemory[addr];
			expectedResults.push_back(item);
		end
	end
	expectedDones.push_back(token.tag);				// Length zero still ends with done
endfunction

`endif

// ==== testbench/loadStoreUnitTb.sv ====
////////////////////
// Testbench for the strided load/store unit
// Random commands from a fixed seed are checked against the included model
////////////////////
`timescale 1ns/1ps

module loadStoreUnitTb
	import tpuPkg::*;
();

	localparam int QUEUE_DEPTH = 8;
	localparam int MAX_LEN = 12;
	localparam int RANDOM_COMMANDS = 40;
	localparam int TOTAL_COMMANDS = RANDOM_COMMANDS + QUEUE_DEPTH + 4;
	localparam int TIMEOUT_CYCLES = TOTAL_COMMANDS * (MAX_LEN + 2) * 6 + 500;

	logic clock;
	logic reset;
	logic stall;
	logic nextStall;
	logic cmdReq;
	accessDesc_t cmdDesc;
	ldstToken_t cmdToken;
	logic cmdStall;
	logic resultValid;
	ldstResult_t result;
	logic doneValid;
	logic [TAG_WIDTH-1:0] doneTag;

	integer seed;
	integer stallSeed;
	int cycleCount;
	int fillCount;									// Accepted commands while pops are held off
	string testName;
	bit quietCheck;
	bit fillCheck;
	bit holdStall;
	bit pulseStall;
	ldstResult_t expectedItem;
	logic [TAG_WIDTH-1:0] expectedTag;
	accessDesc_t directedDesc;
	ldstToken_t directedToken;

	`include "ldstModel.svh"

	loadStoreUnit #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) UUT (
		.clock(clock),
		.reset(reset),
		.stall(stall),
		.cmdReq(cmdReq),
		.cmdDesc(cmdDesc),
		.cmdToken(cmdToken),
		.cmdStall(cmdStall),
		.resultValid(resultValid),
		.result(result),
		.doneValid(doneValid),
		.doneTag(doneTag)
	);

	always #4 clock = ~clock;

	////////////////////
	// Failure reporting
	task automatic stopWithFailure(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			stopWithFailure($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
		end
	endtask

	always @(posedge clock) begin
		if (cycleCount >= TIMEOUT_CYCLES) begin
			stopWithFailure("timeout: the unit stopped finishing commands");
		end else begin
			cycleCount++;
		end
	end

	// Stall level is picked at the edge and changes just after it
	always @(posedge clock) begin
		nextStall = holdStall || (pulseStall && (($random(stallSeed) & 3) == 0));
		#1;
		stall = nextStall;
	end

	////////////////////
	// Monitor, sampled at the falling edge where everything is settled
	always @(negedge clock) begin
		if (!reset) begin
			if (quietCheck) begin
				checkValue({testName, " outputs"}, 32'd0, {29'd0, resultValid, doneValid, cmdStall});
			end
			if (resultValid) begin
				if (expectedResults.size() == 0) begin
					stopWithFailure("a load result arrived with no load element outstanding");
				end else begin
					expectedItem = expectedResults.pop_front();
					checkValue({testName, " result"}, 32'(expectedItem), 32'(result));
				end
			end
			if (doneValid) begin
				if (expectedDones.size() == 0) begin
					stopWithFailure("a done pulse arrived with no command outstanding");
				end else begin
					expectedTag = expectedDones.pop_front();
					checkValue({testName, " done tag"}, 32'(expectedTag), 32'(doneTag));
				end
			end
			if (fillCheck) begin
				checkValue({testName, " cmdStall"}, 32'(fillCount == QUEUE_DEPTH), 32'(cmdStall));
			end
			if (cmdReq && !cmdStall) begin				// Written on the coming edge
				modelCommand(cmdDesc, cmdToken);
				if (fillCheck) begin
					fillCount++;
				end
			end
		end
	end

	////////////////////
	// Stimulus tasks, entered 1 ns after a rising edge
	task automatic sendCommand(input accessDesc_t desc, input ldstToken_t token);
		cmdReq = 1'b1;
		cmdDesc = desc;
		cmdToken = token;
		@(negedge clock);
		while (cmdStall) begin
			@(negedge clock);						// Hold while the queue is full
		end
		@(posedge clock);
		#1;
		cmdReq = 1'b0;
	endtask

	task automatic sendRandom(input bit shortLength);
		accessDesc_t desc;
		ldstToken_t token;
		desc.base = address_t'($random(seed));
		case ($random(seed) & 3)
			0: desc.stride = '0;					// Same word every element
			1: desc.stride = address_t'($random(seed)) | 8'hc0;	// Wraps within a few elements
			default: desc.stride = address_t'($random(seed));
		endcase
		if (shortLength) begin
			desc.length = address_t'(1 + (($random(seed) & 32'h7fff) % 3));
		end else if (($random(seed) & 7) == 0) begin
			desc.length = '0;
		end else begin
			desc.length = address_t'(1 + (($random(seed) & 32'h7fff) % MAX_LEN));
		end
		token.op = ($random(seed) & 1) ? OP_STORE : OP_LOAD;
		token.tag = 4'($random(seed));
		token.storeValue = data_t'($random(seed));
		sendCommand(desc, token);
	endtask

	task automatic waitForDrain();
		do begin
			@(posedge clock);
			#1;
		end while (expectedDones.size() != 0);
	endtask

	////////////////////
	// Test sequence
	initial begin
		seed = 32'hb8a9;
		stallSeed = 32'hb8a9;
		clock = 1'b0;
		reset = 1'b1;
		stall = 1'b0;
		cmdReq = 1'b0;
		cmdDesc = '0;
		cmdToken = '0;
		cycleCount = 0;
		fillCount = 0;
		quietCheck = 1'b0;
		fillCheck = 1'b0;
		holdStall = 1'b0;
		pulseStall = 1'b0;
		testName = "reset";
		modelReset();
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;

		testName = "idle";
		quietCheck = 1'b1;
		repeat (5) @(posedge clock);
		#1;
		quietCheck = 1'b0;

		// Memory starts at zero
		testName = "zero load";
		directedDesc = '{base: 8'h10, stride: 8'd3, length: 8'd6};
		directedToken = '{op: OP_LOAD, tag: 4'd1, storeValue: 16'h0000};
		sendCommand(directedDesc, directedToken);
		waitForDrain();

		testName = "store then load";
		directedDesc = '{base: 8'hf8, stride: 8'd5, length: 8'd8};	// Crosses the top
		directedToken = '{op: OP_STORE, tag: 4'd2, storeValue: 16'hbeef};
		sendCommand(directedDesc, directedToken);
		directedToken = '{op: OP_LOAD, tag: 4'd3, storeValue: 16'h0000};
		sendCommand(directedDesc, directedToken);
		waitForDrain();

		testName = "random";
		pulseStall = 1'b1;
		for (int i = 0; i < RANDOM_COMMANDS; i++) begin
			sendRandom(1'b0);
		end
		waitForDrain();
		pulseStall = 1'b0;

		// Pops held off, so occupancy follows accepts alone
		testName = "queue fill";
		@(posedge clock);
		#1;
		holdStall = 1'b1;
		@(posedge clock);
		#1;
		fillCount = 0;
		fillCheck = 1'b1;
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			sendRandom(1'b1);
		end
		fork
			sendRandom(1'b1);						// Waits on the full queue
			begin
				repeat (4) @(posedge clock);
				#1;
				fillCheck = 1'b0;
				holdStall = 1'b0;
			end
		join
		waitForDrain();

		if (expectedResults.size() == 0 && expectedDones.size() == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			stopWithFailure("load results were still outstanding at the end of the run");
		end
	end

endmodule

// ==== rtl/loadStoreUnit.sv ====
////////////////////
// Strided load/store unit top level
// Command queue feeds the address generator, which drives the data memory
////////////////////
`timescale 1ns/1ps

module loadStoreUnit
	import tpuPkg::*;
#(
	parameter int QUEUE_DEPTH = 8,
	parameter int MEM_DEPTH = 256
)(
	input logic clock,
	input logic reset,
	input logic stall,
	input logic cmdReq,
	input accessDesc_t cmdDesc,
	input ldstToken_t cmdToken,
	output logic cmdStall,
	output logic resultValid,
	output ldstResult_t result,
	output logic doneValid,
	output logic [TAG_WIDTH-1:0] doneTag
);

	////////////////////
	// Queue to generator
	logic headReq;
	logic grant;
	accessDesc_t headDesc;
	ldstToken_t headToken;

	// Generator to memory
	logic memReq;
	address_t memAddr;
	logic memWrite;
	data_t memWriteData;
	logic memAck;
	data_t memReadData;

	loadStoreTokenQueue #(
		.QUEUE_DEPTH(QUEUE_DEPTH),
		.TYPE(ldstToken_t)
	) commandQueue (
		.clock(clock),
		.reset(reset),
		.stall(stall),
		.grant(grant),
		.cmdReq(cmdReq),
		.cmdDesc(cmdDesc),
		.cmdToken(cmdToken),
		.headReq(headReq),
		.headDesc(headDesc),
		.headToken(headToken),
		.cmdStall(cmdStall),
		.empty()
	);

	strideAddressGenerator addressGenerator (
		.clock(clock),
		.reset(reset),
		.stall(stall),
		.headReq(headReq),
		.headDesc(headDesc),
		.headToken(headToken),
		.grant(grant),
		.memReq(memReq),
		.memAddr(memAddr),
		.memWrite(memWrite),
		.memWriteData(memWriteData),
		.memAck(memAck),
		.memReadData(memReadData),
		.resultValid(resultValid),
		.result(result),
		.doneValid(doneValid),
		.doneTag(doneTag)
	);

	dataMemory #(
		.MEM_DEPTH(MEM_DEPTH)
	) memory (
		.clock(clock),
		.reset(reset),
		.memReq(memReq),
		.memAddr(memAddr),
		.memWrite(memWrite),
		.memWriteData(memWriteData),
		.memAck(memAck),
		.memReadData(memReadData)
	);

endmodule

// ==== rtl/dataMemory.sv ====
////////////////////
// Single-port word memory behind a four-phase req/ack handshake
// Access happens once, on the edge that raises ack
////////////////////
`timescale 1ns/1ps

module dataMemory
	import tpuPkg::*;
#(
	parameter int MEM_DEPTH = 256
)(
	input logic clock,
	input logic reset,
	input logic memReq,
	input address_t memAddr,
	input logic memWrite,
	input data_t memWriteData,
	output logic memAck,
	output data_t memReadData
);

	localparam int MEM_ADDR_WIDTH = $clog2(MEM_DEPTH);

	data_t words [MEM_DEPTH];

	logic accessStrobe;
	logic [MEM_ADDR_WIDTH-1:0] wordIndex;

	assign accessStrobe = memReq & ~memAck;			// New request seen
	assign wordIndex = memAddr[MEM_ADDR_WIDTH-1:0];	// Smaller instances alias upper addresses

	////////////////////
	// Handshake and storage
	always_ff @(posedge clock) begin
		if (reset) begin
			memAck <= 1'b0;
			for (int i = 0; i < MEM_DEPTH; i++) begin
				words[i] <= '0;
			end
		end else begin
			if (accessStrobe) begin
				memAck <= 1'b1;
				if (memWrite) begin
					words[wordIndex] <= memWriteData;
				end
			end else if (!memReq && memAck) begin
				memAck <= 1'b0;						// Release phase
			end
		end
	end

	// Read data, held until the next load
	always_ff @(posedge clock) begin
		if (accessStrobe && !memWrite) begin
			memReadData <= words[wordIndex];
		end
	end

	// A new request waits until the previous ack has been released
	noReqDuringRelease: assert property (
		@(posedge clock) disable iff (reset)
		memAck && !memReq |=> !memReq
	);

endmodule

// ==== rtl/strideAddressGenerator.sv ====
////////////////////
// Walks the elements of one granted command at base + i * stride
// Each element is one four-phase req/ack exchange with the data memory
// Loads return every element, every command ends with a done pulse
////////////////////
`timescale 1ns/1ps

module strideAddressGenerator
	import tpuPkg::*;
(
	input logic clock,
	input logic reset,
	input logic stall,
	input logic headReq,
	input accessDesc_t headDesc,
	input ldstToken_t headToken,
	output logic grant,
	output logic memReq,
	output address_t memAddr,
	output logic memWrite,
	output data_t memWriteData,
	input logic memAck,
	input data_t memReadData,
	output logic resultValid,
	output ldstResult_t result,
	output logic doneValid,
	output logic [TAG_WIDTH-1:0] doneTag
);

	typedef enum logic [1:0] {
		IDLE,
		REQUEST,
		WAIT_RELEASE,
		FINISH
	} genState_t;

	genState_t state;
	accessDesc_t cmdDesc;							// Captured at grant
	ldstToken_t cmdToken;
	address_t curAddress;
	address_t elemIndex;

	assign grant = (state == IDLE) & headReq;		// headReq already masks stall
	assign memReq = state == REQUEST;
	assign memAddr = curAddress;
	assign memWrite = cmdToken.op == OP_STORE;
	assign memWriteData = cmdToken.storeValue;
	assign doneValid = state == FINISH;
	assign doneTag = cmdToken.tag;

	////////////////////
	// Control FSM
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			resultValid <= 1'b0;
		end else begin
			resultValid <= 1'b0;
			case (state)
				IDLE: begin
					if (grant) begin
						state <= (headDesc.length == '0) ? FINISH : REQUEST;
					end
				end
				REQUEST: begin
					if (memAck) begin
						state <= WAIT_RELEASE;		// Drop req after ack
						resultValid <= cmdToken.op == OP_LOAD;
					end
				end
				WAIT_RELEASE: begin
					if (!memAck) begin
						if (elemIndex == cmdDesc.length) begin
							state <= FINISH;
						end else if (!stall) begin
							state <= REQUEST;		// Stall holds off the next element only
						end
					end
				end
				default: state <= IDLE;				// FINISH lasts one cycle
			endcase
		end
	end

	////////////////////
	// Command and element registers
	always_ff @(posedge clock) begin
		if (grant) begin
			cmdDesc <= headDesc;
			cmdToken <= headToken;
			curAddress <= headDesc.base;
			elemIndex <= '0;
		end
		if (state == REQUEST && memAck) begin
			result <= '{tag: cmdToken.tag, index: elemIndex, data: memReadData};
			curAddress <= curAddress + cmdDesc.stride;	// Natural 8-bit wrap
			elemIndex <= elemIndex + 1'b1;
		end
	end

	// Request and its payload hold until the memory answers
	reqHeldUntilAck: assert property (
		@(posedge clock) disable iff (reset)
		memReq && !memAck |=> memReq && $stable(memAddr) && $stable(memWrite)
			&& $stable(memWriteData)
	);

	// A pop only happens with the memory ack released
	grantOnlyWhenQuiet: assert property (
		@(posedge clock) disable iff (reset)
		grant |-> !memAck
	);

endmodule

// ==== rtl/loadStoreTokenQueue.sv ====
////////////////////
// Command queue holding access descriptors and their tokens
// Head is popped by a one-cycle grant from the address generator
// Input side stalls while the queue is full
////////////////////
`timescale 1ns/1ps

module loadStoreTokenQueue
	import tpuPkg::*;
#(
	parameter int QUEUE_DEPTH = 8,
	parameter type TYPE = ldstToken_t
)(
	input logic clock,
	input logic reset,
	input logic stall,
	input logic grant,
	input logic cmdReq,
	input accessDesc_t cmdDesc,
	input TYPE cmdToken,
	output logic headReq,
	output accessDesc_t headDesc,
	output TYPE headToken,
	output logic cmdStall,
	output logic empty
);

	localparam int PTR_WIDTH = $clog2(QUEUE_DEPTH);

	accessDesc_t descBuffer [QUEUE_DEPTH];
	TYPE tokenBuffer [QUEUE_DEPTH];

	logic writeEnable;
	logic readEnable;
	logic [PTR_WIDTH-1:0] writeAddress;
	logic [PTR_WIDTH-1:0] readAddress;
	logic full;

	assign writeEnable = cmdReq & ~full;
	assign readEnable = grant & ~empty;

	assign headReq = ~empty & ~stall;				// Offer head only when not held off
	assign headDesc = descBuffer[readAddress];
	assign headToken = tokenBuffer[readAddress];
	assign cmdStall = full;

	// Entry storage
	always_ff @(posedge clock) begin
		if (writeEnable) begin
			descBuffer[writeAddress] <= cmdDesc;
			tokenBuffer[writeAddress] <= cmdToken;
		end
	end

	ringBufferControl #(
		.NUM_ENTRY(QUEUE_DEPTH),
		.PTR_WIDTH(PTR_WIDTH)
	) ringControl (
		.clock(clock),
		.reset(reset),
		.write(writeEnable),
		.read(readEnable),
		.writeAddress(writeAddress),
		.readAddress(readAddress),
		.full(full),
		.empty(empty),
		.count()
	);

	// Generator must never pop a missing entry
	noGrantWhenEmpty: assert property (
		@(posedge clock) disable iff (reset)
		grant |-> !empty
	);

endmodule

// ==== rtl/ringBufferControl.sv ====
////////////////////
// Pointer and occupancy control for a circular buffer
// Caller gates write with not-full and read with not-empty
////////////////////
`timescale 1ns/1ps

module ringBufferControl #(
	parameter int NUM_ENTRY = 8,
	parameter int PTR_WIDTH = $clog2(NUM_ENTRY)
)(
	input logic clock,
	input logic reset,
	input logic write,
	input logic read,
	output logic [PTR_WIDTH-1:0] writeAddress,
	output logic [PTR_WIDTH-1:0] readAddress,
	output logic full,
	output logic empty,
	output logic [PTR_WIDTH:0] count
);

	localparam logic [PTR_WIDTH-1:0] LAST_PTR = PTR_WIDTH'(NUM_ENTRY - 1);
	localparam logic [PTR_WIDTH:0] FULL_COUNT = (PTR_WIDTH + 1)'(NUM_ENTRY);

	assign full = count == FULL_COUNT;
	assign empty = count == '0;

	always_ff @(posedge clock) begin
		if (reset) begin
			writeAddress <= '0;
			readAddress <= '0;
			count <= '0;
		end else begin
			if (write) begin
				writeAddress <= (writeAddress == LAST_PTR) ? '0 : writeAddress + 1'b1;
			end
			if (read) begin
				readAddress <= (readAddress == LAST_PTR) ? '0 : readAddress + 1'b1;
			end
			case ({write, read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;			// Both or neither
			endcase
		end
	end

	// Occupancy stays within the buffer across any strobe sequence
	countBounded: assert property (
		@(posedge clock) disable iff (reset)
		count <= FULL_COUNT
	);

endmodule

// ==== rtl/tpuPkg.sv ====
////////////////////
// Shared types of the strided load/store unit
// Modules pull them in with a wildcard import in their header
////////////////////
package tpuPkg;

	localparam int ADDR_WIDTH = 8;
	localparam int DATA_WIDTH = 16;
	localparam int TAG_WIDTH = 4;

	typedef logic [ADDR_WIDTH-1:0] address_t;		// Memory word address
	typedef logic [DATA_WIDTH-1:0] data_t;			// Memory word

	////////////////////
	// Command side

	// One strided access, 24 bits
	typedef struct packed {
		address_t base;
		address_t stride;
		address_t length;							// Element count, zero allowed
	} accessDesc_t;

	typedef enum logic {
		OP_LOAD = 1'b0,
		OP_STORE = 1'b1
	} ldstOp_t;

	// Payload beside the descriptor, 21 bits
	typedef struct packed {
		ldstOp_t op;
		logic [TAG_WIDTH-1:0] tag;
		data_t storeValue;							// Written to every element of a store
	} ldstToken_t;

	////////////////////
	// Result side

	// One returned load element, 28 bits
	typedef struct packed {
		logic [TAG_WIDTH-1:0] tag;
		address_t index;							// Element number within the command
		data_t data;
	} ldstResult_t;

endpackage
